// ==== hdl/cdb_arbiter.sv ====
/*
 * ALU and CDB arbiter
 * One-cycle ALU into a holding register; multiplier owns the bus when valid
 */
`timescale 1ns/1ps

module cdb_arbiter
    import ooo_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  exec_packet_t alu_issue,
    input  cdb_packet_t  mul_result,
    output logic         alu_ready,
    output cdb_packet_t  cdb
);

    logic              alu_valid;
    logic [TAG_W-1:0]  alu_tag;
    logic [DATA_W-1:0] alu_data;
    logic [DATA_W-1:0] alu_value;

    always_comb begin
        case (alu_issue.op)
            OP_ADD:  alu_value = alu_issue.a + alu_issue.b;
            OP_SUB:  alu_value = alu_issue.a - alu_issue.b;
            OP_AND:  alu_value = alu_issue.a & alu_issue.b;
            OP_XOR:  alu_value = alu_issue.a ^ alu_issue.b;
            // Immediate already sits in operand 1
            OP_LI:   alu_value = alu_issue.a;
            default: alu_value = '0;
        endcase
    end

    assign alu_ready = !alu_valid;
    assign cdb = mul_result.valid ? mul_result : '{valid: alu_valid, tag: alu_tag, value: alu_data};

    always_ff @(posedge clock) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else if (alu_issue.valid) begin
            alu_valid <= 1'b1;
        end else if (!mul_result.valid) begin
            // Held result got the bus this cycle
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_issue.valid) begin
            alu_tag  <= alu_issue.tag;
            alu_data <= alu_value;
        end
    end

    // Station honours alu_ready, so a pending result is never replaced
    a_hold_safe: assert property (@(posedge clock) disable iff (rst)
        alu_issue.valid |-> !alu_valid);

endmodule

// ==== hdl/insn_buffer.sv ====
/*
 * Instruction buffer
 * Four-phase req/ack receiver feeding a small circular FIFO
 */
`timescale 1ns/1ps

module insn_buffer
    import ooo_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  logic  insn_req,
    input  insn_t insn,
    input  logic  pop,
    output logic  insn_ack,
    output insn_t head,
    output logic  empty
);

    insn_t               slots [IB_DEPTH];
    logic [IB_PTR_W-1:0] wr_ptr;
    logic [IB_PTR_W-1:0] rd_ptr;
    logic [IB_PTR_W:0]   count;
    logic                push;

    // New request, previous one closed, room left
    assign push  = insn_req && !insn_ack && (count != (IB_PTR_W+1)'(IB_DEPTH));
    assign empty = (count == '0);
    assign head  = slots[rd_ptr];

    always_ff @(posedge clock) begin
        if (rst) begin
            insn_ack <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                insn_ack <= 1'b1;
                wr_ptr   <= wr_ptr + 1'b1;
            end else if (!insn_req) begin
                // Source has withdrawn, close the handshake
                insn_ack <= 1'b0;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (IB_PTR_W+1)'(push) - (IB_PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            slots[wr_ptr] <= insn;
        end
    end

    // Dispatch only pops a buffer that holds something
    a_no_pop_empty: assert property (@(posedge clock) disable iff (rst) pop |-> !empty);

endmodule

// ==== hdl/mul_pipe.sv ====
/*
 * Pipelined multiplier
 * Three stages with valid and tag shifted alongside, product kept to DATA_W
 */
`timescale 1ns/1ps

module mul_pipe
    import ooo_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  exec_packet_t issue,
    output cdb_packet_t  result
);

    logic [MUL_STAGES-1:0] vld;
    logic [TAG_W-1:0]      tag_q [MUL_STAGES];
    logic [DATA_W-1:0]     a_q;
    logic [DATA_W-1:0]     b_q;
    logic [DATA_W-1:0]     pp_lo;
    logic [HALF_W-1:0]     pp_hi;
    logic [DATA_W-1:0]     sum_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[MUL_STAGES-2:0], issue.valid};
        end
    end

    always_ff @(posedge clock) begin
        tag_q[0] <= issue.tag;
        for (int s = 1; s < MUL_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
        // Stage 1, operand capture
        a_q <= issue.a;
        b_q <= issue.b;
        // Stage 2, partial products; upper half only matters mod 2^HALF_W
        pp_lo <= DATA_W'(a_q[HALF_W-1:0]) * b_q;
        pp_hi <= a_q[DATA_W-1:HALF_W] * b_q[HALF_W-1:0];
        // Stage 3, recombine
        sum_q <= pp_lo + {pp_hi, {HALF_W{1'b0}}};
    end

    assign result.valid = vld[MUL_STAGES-1];
    assign result.tag   = tag_q[MUL_STAGES-1];
    assign result.value = sum_q;

endmodule

// ==== hdl/ooo_core.sv ====
/*
 * Out-of-order core top level
 * Connects buffer, rename, station, units, CDB and ROB; forms dispatch
 */
`timescale 1ns/1ps

module ooo_core
    import ooo_pkg::*;
(
    input  logic              clock,
    input  logic              rst,
    input  logic              insn_req,
    input  insn_t             insn,
    output logic              insn_ack,
    output logic              commit_valid,
    output logic [REG_W-1:0]  commit_rd,
    output logic [DATA_W-1:0] commit_data
);

    insn_t            ib_head;
    logic             ib_empty;
    logic             rs_full;
    logic             rob_full;
    logic             alu_ready;
    logic             dispatch;
    logic [TAG_W-1:0] rob_tail;
    operand_t         src_a;
    operand_t         src_b;
    dp_packet_t       dp;
    exec_packet_t     alu_issue;
    exec_packet_t     mul_issue;
    cdb_packet_t      mul_result;
    cdb_packet_t      cdb;
    retire_packet_t   retire;

    //////////////////////////////////////////////////
    // Dispatch
    //////////////////////////////////////////////////

    assign dispatch = !ib_empty && !rs_full && !rob_full;

    always_comb begin
        dp.op   = ib_head.op;
        dp.tag  = rob_tail;
        dp.src1 = src_a;
        dp.src2 = src_b;
        // LI reads no register
        if (ib_head.op == OP_LI) begin
            dp.src1 = '{ready: 1'b1, tag: '0, value: DATA_W'(ib_head.imm)};
            dp.src2 = '{ready: 1'b1, tag: '0, value: '0};
        end
    end

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    insn_buffer u_insn_buffer (
        .clock, .rst, .insn_req, .insn,
        .pop   (dispatch),
        .insn_ack,
        .head  (ib_head),
        .empty (ib_empty)
    );

    reg_state u_reg_state (
        .clock, .rst,
        .rd_idx_a   (ib_head.rs1),
        .rd_idx_b   (ib_head.rs2),
        .rename_en  (dispatch),
        .rename_rd  (ib_head.rd),
        .rename_tag (rob_tail),
        .cdb, .retire, .src_a, .src_b
    );

    res_station u_res_station (
        .clock, .rst, .dispatch, .dp, .cdb, .alu_ready,
        .full (rs_full),
        .alu_issue, .mul_issue
    );

    mul_pipe u_mul_pipe (
        .clock, .rst,
        .issue  (mul_issue),
        .result (mul_result)
    );

    cdb_arbiter u_cdb_arbiter (
        .clock, .rst, .alu_issue, .mul_result, .alu_ready, .cdb
    );

    rob u_rob (
        .clock, .rst,
        .alloc    (dispatch),
        .alloc_rd (ib_head.rd),
        .cdb,
        .full     (rob_full),
        .tail_tag (rob_tail),
        .retire
    );

    // Retirement is the commit
    assign commit_valid = retire.valid;
    assign commit_rd    = retire.rd;
    assign commit_data  = retire.value;

endmodule

// ==== hdl/ooo_pkg.sv ====
/*
 * Shared definitions for the out-of-order integer core
 * Widths, sizes, opcodes and the packets passed between stages
 */
package ooo_pkg;

    // Architectural state
    localparam int NUM_REGS = 8;
    localparam int REG_W    = 3;
    localparam int DATA_W   = 16;
    localparam int HALF_W   = DATA_W / 2;
    localparam int IMM_W    = 8;

    // Queue sizes and pointer widths
    localparam int ROB_DEPTH  = 8;
    localparam int TAG_W      = 3;
    localparam int RS_DEPTH   = 4;
    localparam int RS_IDX_W   = 2;
    localparam int AGE_W      = 2;
    localparam int IB_DEPTH   = 4;
    localparam int IB_PTR_W   = 2;
    localparam int MUL_STAGES = 3;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4,
        // Zero-extended immediate into rd
        OP_LI  = 3'd5
    } op_e;

    typedef struct packed {
        op_e              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [IMM_W-1:0] imm;
    } insn_t;

    // Either a ready value or the tag of the producer
    typedef struct packed {
        logic              ready;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } operand_t;

    typedef struct packed {
        op_e              op;
        operand_t         src1;
        operand_t         src2;
        logic [TAG_W-1:0] tag;
    } dp_packet_t;

    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [TAG_W-1:0]  tag;
    } exec_packet_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } cdb_packet_t;

    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  rd;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } retire_packet_t;

endpackage

// ==== hdl/reg_state.sv ====
/*
 * Register state
 * Architectural values plus rename tags, read at dispatch, written at retire
 */
`timescale 1ns/1ps

module reg_state
    import ooo_pkg::*;
(
    input  logic             clock,
    input  logic             rst,
    input  logic [REG_W-1:0] rd_idx_a,
    input  logic [REG_W-1:0] rd_idx_b,
    input  logic             rename_en,
    input  logic [REG_W-1:0] rename_rd,
    input  logic [TAG_W-1:0] rename_tag,
    input  cdb_packet_t      cdb,
    input  retire_packet_t   retire,
    output operand_t         src_a,
    output operand_t         src_b
);

    logic [DATA_W-1:0]   arch_val [NUM_REGS];
    logic [DATA_W-1:0]   spec_val [NUM_REGS];
    logic [TAG_W-1:0]    tag_map  [NUM_REGS];
    logic [NUM_REGS-1:0] busy;
    // Producer has broadcast but not yet retired
    logic [NUM_REGS-1:0] done;

    function automatic operand_t lookup(input logic [REG_W-1:0] idx);
        operand_t opnd;
        opnd.ready = 1'b1;
        opnd.tag   = tag_map[idx];
        opnd.value = arch_val[idx];
        if (busy[idx]) begin
            if (done[idx]) begin
                opnd.value = spec_val[idx];
            end else if (cdb.valid && cdb.tag == tag_map[idx]) begin
                // Bypass the broadcast of this very cycle
                opnd.value = cdb.value;
            end else begin
                opnd.ready = 1'b0;
            end
        end
        return opnd;
    endfunction

    always_comb begin
        src_a = lookup(rd_idx_a);
        src_b = lookup(rd_idx_b);
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= '0;
            done <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                arch_val[r] <= '0;
            end
        end else begin
            if (retire.valid) begin
                arch_val[retire.rd] <= retire.value;
                // Younger rename keeps its tag
                if (busy[retire.rd] && tag_map[retire.rd] == retire.tag) begin
                    busy[retire.rd] <= 1'b0;
                end
            end
            for (int r = 0; r < NUM_REGS; r++) begin
                if (busy[r] && cdb.valid && cdb.tag == tag_map[r]) begin
                    done[r]     <= 1'b1;
                    spec_val[r] <= cdb.value;
                end
            end
            // Rename comes last and wins over the updates above
            if (rename_en) begin
                busy[rename_rd]    <= 1'b1;
                done[rename_rd]    <= 1'b0;
                tag_map[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

// ==== hdl/res_station.sv ====
/*
 * Reservation station
 * Holds dispatched operations, wakes operands from the CDB and
 * issues the oldest ready entry to the ALU and to the multiplier
 */
`timescale 1ns/1ps

module res_station
    import ooo_pkg::*;
(
    input  logic         clock,
    input  logic         rst,
    input  logic         dispatch,
    input  dp_packet_t   dp,
    input  cdb_packet_t  cdb,
    input  logic         alu_ready,
    output logic         full,
    output exec_packet_t alu_issue,
    output exec_packet_t mul_issue
);

    dp_packet_t          ent      [RS_DEPTH];
    // Age is the count of younger busy entries, so the oldest has the largest
    logic [AGE_W-1:0]    age      [RS_DEPTH];
    logic [AGE_W-1:0]    age_next [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy;
    logic [RS_IDX_W-1:0] alu_sel;
    logic [RS_IDX_W-1:0] mul_sel;
    logic [RS_IDX_W-1:0] free_sel;
    logic                alu_found;
    logic                alu_take;

    function automatic operand_t wake(input operand_t opnd, input cdb_packet_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    assign full     = &busy;
    assign alu_take = alu_found && alu_ready;

    //////////////////////////////////////////////////
    // Selection
    //////////////////////////////////////////////////

    always_comb begin
        alu_found       = 1'b0;
        mul_issue.valid = 1'b0;
        alu_sel         = '0;
        mul_sel         = '0;
        free_sel        = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            // Lowest free slot for dispatch
            if (!busy[i]) begin
                free_sel = RS_IDX_W'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (busy[i] && ent[i].src1.ready && ent[i].src2.ready) begin
                if (ent[i].op == OP_MUL) begin
                    if (!mul_issue.valid || age[i] > age[mul_sel]) begin
                        mul_issue.valid = 1'b1;
                        mul_sel         = RS_IDX_W'(i);
                    end
                end else if (!alu_found || age[i] > age[alu_sel]) begin
                    alu_found = 1'b1;
                    alu_sel   = RS_IDX_W'(i);
                end
            end
        end
        alu_issue.valid = alu_take;
        alu_issue.op    = ent[alu_sel].op;
        alu_issue.a     = ent[alu_sel].src1.value;
        alu_issue.b     = ent[alu_sel].src2.value;
        alu_issue.tag   = ent[alu_sel].tag;
        mul_issue.op    = ent[mul_sel].op;
        mul_issue.a     = ent[mul_sel].src1.value;
        mul_issue.b     = ent[mul_sel].src2.value;
        mul_issue.tag   = ent[mul_sel].tag;
    end

    // Older entries count the newcomer, lose the younger ones that leave
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            age_next[i] = age[i] + AGE_W'(dispatch);
            if (alu_take && age[alu_sel] < age[i]) begin
                age_next[i] = age_next[i] - 1'b1;
            end
            if (mul_issue.valid && age[mul_sel] < age[i]) begin
                age_next[i] = age_next[i] - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Entry state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if ((alu_take && alu_sel == i) || (mul_issue.valid && mul_sel == i)) begin
                    busy[i] <= 1'b0;
                end else if (dispatch && free_sel == i) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatch && free_sel == i) begin
                ent[i] <= dp;
                age[i] <= '0;
            end else begin
                ent[i].src1 <= wake(ent[i].src1, cdb);
                ent[i].src2 <= wake(ent[i].src2, cdb);
                age[i]      <= age_next[i];
            end
        end
    end

    // Issued operands must have been woken by an earlier broadcast or dispatch
    a_alu_ready_ops: assert property (@(posedge clock) disable iff (rst)
        alu_issue.valid |-> ent[alu_sel].src1.ready && ent[alu_sel].src2.ready);
    a_mul_ready_ops: assert property (@(posedge clock) disable iff (rst)
        mul_issue.valid |-> ent[mul_sel].src1.ready && ent[mul_sel].src2.ready);

endmodule

// ==== hdl/rob.sv ====
/*
 * Reorder buffer
 * Allocates at dispatch, marks completion from the CDB, retires in order
 */
`timescale 1ns/1ps

module rob
    import ooo_pkg::*;
(
    input  logic             clock,
    input  logic             rst,
    input  logic             alloc,
    input  logic [REG_W-1:0] alloc_rd,
    input  cdb_packet_t      cdb,
    output logic             full,
    output logic [TAG_W-1:0] tail_tag,
    output retire_packet_t   retire
);

    logic [REG_W-1:0]     rd_q  [ROB_DEPTH];
    logic [DATA_W-1:0]    val_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;
    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;
    logic [TAG_W:0]       count;

    assign full     = (count == (TAG_W+1)'(ROB_DEPTH));
    assign tail_tag = tail;

    // Head leaves as soon as its result has arrived
    always_comb begin
        retire.valid = (count != '0) && done[head];
        retire.rd    = rd_q[head];
        retire.tag   = head;
        retire.value = val_q[head];
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (retire.valid) begin
                head <= head + 1'b1;
            end
            count <= count + (TAG_W+1)'(alloc) - (TAG_W+1)'(retire.valid);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (cdb.valid) begin
            val_q[cdb.tag] <= cdb.value;
        end
    end

    // Dispatch condition at the top level must respect a full buffer
    a_no_alloc_full: assert property (@(posedge clock) disable iff (rst) alloc |-> !full);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the out-of-order core testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_ooo_core -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    exit 0
fi
exit 1

// ==== sim.f ====
hdl/ooo_pkg.sv
hdl/insn_buffer.sv
hdl/reg_state.sv
hdl/res_station.sv
hdl/mul_pipe.sv
hdl/cdb_arbiter.sv
hdl/rob.sv
hdl/ooo_core.sv
tb/tb_ooo_core.sv

// ==== tb/tb_ooo_core.sv ====
/*
 * Testbench for the out-of-order core
 * Feeds a directed and random program over the four-phase port and
 * checks every commit against an in-order register model
 */
`timescale 1ns/1ps

module tb_ooo_core
    import ooo_pkg::*;
();

    // Sixty instructions at forty cycles each
    localparam int MAX_CYCLES = 60 * 40;

    typedef struct packed {
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] value;
    } expect_t;

    logic              clock;
    logic              rst;
    logic              insn_req;
    insn_t             insn;
    logic              insn_ack;
    logic              commit_valid;
    logic [REG_W-1:0]  commit_rd;
    logic [DATA_W-1:0] commit_data;

    integer            seed;
    int                cycle_count;
    int                sent_count;
    int                commit_count;
    int                value_errs;
    int                proto_errs;
    logic [DATA_W-1:0] model_regs [NUM_REGS];
    expect_t           exp_q [$];
    expect_t           exp_head;

    ooo_core UUT (
        .clock, .rst, .insn_req, .insn,
        .insn_ack, .commit_valid, .commit_rd, .commit_data
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic insn_t encode(input op_e op, input int rd, input int rs1,
                                     input int rs2, input int imm);
        insn_t ins;
        ins.op  = op;
        ins.rd  = REG_W'(rd);
        ins.rs1 = REG_W'(rs1);
        ins.rs2 = REG_W'(rs2);
        ins.imm = IMM_W'(imm);
        return ins;
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // In-order meaning of one instruction, all arithmetic mod 2^16
    function automatic logic [DATA_W-1:0] model_result(input insn_t ins);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        a = model_regs[ins.rs1];
        b = model_regs[ins.rs2];
        case (ins.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            OP_LI:   return {{(DATA_W-IMM_W){1'b0}}, ins.imm};
            default: return '0;
        endcase
    endfunction

    // One four-phase transfer; the model runs when the core accepts
    task automatic send(input insn_t ins, input bit quick);
        int      gap;
        expect_t item;
        gap = quick ? 0 : rand_below(4);
        repeat (gap) @(negedge clock);
        insn     = ins;
        insn_req = 1'b1;
        do @(negedge clock); while (!insn_ack);
        item.rd    = ins.rd;
        item.value = model_result(ins);
        exp_q.push_back(item);
        model_regs[ins.rd] = item.value;
        sent_count++;
        insn_req = 1'b0;
        do @(negedge clock); while (insn_ack);
    endtask

    task automatic report_and_finish();
        $display("Error counts: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Four-phase rules seen at the port
    a_ack_rise: assert property (@(posedge clock) disable iff (rst)
        $rose(insn_ack) |-> $past(insn_req))
        else begin
            proto_errs++;
            $display("insn_ack rose without a pending request");
        end
    a_ack_fall: assert property (@(posedge clock) disable iff (rst)
        $fell(insn_ack) |-> !$past(insn_req))
        else begin
            proto_errs++;
            $display("insn_ack fell while the request was still high");
        end
    a_req_fall: assert property (@(posedge clock) disable iff (rst)
        $fell(insn_req) |-> insn_ack)
        else begin
            proto_errs++;
            $display("insn_req dropped before it was acknowledged");
        end

    // Commits in program order against the model, sampled mid-cycle
    always @(negedge clock) begin
        if (!rst && commit_valid) begin
            commit_count++;
            a_commit_known: assert (exp_q.size() != 0)
                else begin
                    proto_errs++;
                    $display("Commit seen with no instruction outstanding");
                end
            if (exp_q.size() != 0) begin
                exp_head = exp_q.pop_front();
                a_commit_rd: assert (commit_rd == exp_head.rd)
                    else begin
                        value_errs++;
                        $display("Fail commit_rd: got %h, expected %h",
                                 commit_rd, exp_head.rd);
                    end
                a_commit_data: assert (commit_data == exp_head.value)
                    else begin
                        value_errs++;
                        $display("Fail commit_data: got %h, expected %h",
                                 commit_data, exp_head.value);
                    end
            end
        end
    end

    // Watchdog
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            proto_errs++;
            $display("Run did not finish within %0d cycles", MAX_CYCLES);
            report_and_finish();
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int pick;
        int rd_r;
        int rs1_r;
        int rs2_r;
        int imm_r;
        seed         = 32'hd7c4;
        rst          = 1'b1;
        insn_req     = 1'b0;
        insn         = '0;
        cycle_count  = 0;
        sent_count   = 0;
        commit_count = 0;
        value_errs   = 0;
        proto_errs   = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(negedge clock);
        rst = 1'b0;

        // Quiet outputs right after reset
        repeat (3) begin
            @(negedge clock);
            a_quiet: assert (!commit_valid && !insn_ack)
                else begin
                    proto_errs++;
                    $display("Outputs active in the first cycles after reset");
                end
        end

        // Readers of never written registers see zero
        send(encode(OP_ADD, 1, 2, 3, 0), 1'b0);
        send(encode(OP_XOR, 4, 5, 6, 0), 1'b0);
        send(encode(OP_MUL, 7, 0, 1, 0), 1'b0);
        // Immediates and 16-bit wrap
        send(encode(OP_LI, 1, 0, 0, 'hff), 1'b0);
        send(encode(OP_LI, 2, 0, 0, 'h80), 1'b0);
        send(encode(OP_LI, 3, 0, 0, 'h03), 1'b0);
        send(encode(OP_MUL, 5, 1, 1, 0), 1'b0);
        send(encode(OP_ADD, 6, 5, 5, 0), 1'b0);
        send(encode(OP_SUB, 7, 3, 1, 0), 1'b0);
        send(encode(OP_MUL, 0, 5, 5, 0), 1'b0);
        send(encode(OP_AND, 4, 5, 7, 0), 1'b0);
        send(encode(OP_XOR, 4, 4, 2, 0), 1'b0);
        // MUL to ADD chains with independent ALU work between
        send(encode(OP_MUL, 4, 1, 2, 0), 1'b0);
        send(encode(OP_ADD, 5, 4, 3, 0), 1'b1);
        send(encode(OP_LI, 6, 0, 0, 'h5a), 1'b1);
        send(encode(OP_AND, 7, 1, 6, 0), 1'b1);
        send(encode(OP_MUL, 4, 4, 3, 0), 1'b1);
        send(encode(OP_ADD, 5, 4, 5, 0), 1'b1);
        send(encode(OP_SUB, 6, 5, 7, 0), 1'b0);
        // Younger writer of the same register must win
        send(encode(OP_LI, 2, 0, 0, 'h01), 1'b1);
        send(encode(OP_LI, 2, 0, 0, 'h02), 1'b1);
        send(encode(OP_ADD, 2, 2, 2, 0), 1'b1);
        send(encode(OP_MUL, 3, 1, 1, 0), 1'b1);
        send(encode(OP_LI, 3, 0, 0, 'h07), 1'b1);
        send(encode(OP_ADD, 0, 3, 3, 0), 1'b1);

        // Back-to-back independent multiplies
        for (int k = 0; k < 12; k++) begin
            send(encode(OP_MUL, (k % 6) + 2, 0, 1, 0), 1'b1);
        end

        // Random tail
        for (int k = 0; k < 23; k++) begin
            pick  = rand_below(6);
            rd_r  = rand_below(NUM_REGS);
            rs1_r = rand_below(NUM_REGS);
            rs2_r = rand_below(NUM_REGS);
            imm_r = rand_below(256);
            send(encode(op_e'(pick[2:0]), rd_r, rs1_r, rs2_r, imm_r), 1'b0);
        end

        // Drain, then make sure nothing extra retires
        while (commit_count < sent_count) @(negedge clock);
        repeat (8) @(negedge clock);
        a_all_committed: assert (commit_count == sent_count && exp_q.size() == 0)
            else begin
                value_errs++;
                $display("Fail commit_count: got %h, expected %h",
                         commit_count, sent_count);
            end
        report_and_finish();
    end

endmodule
